//--- rtl/tdc_link_consts.svh
`ifndef TDC_LINK_CONSTS_SVH
`define TDC_LINK_CONSTS_SVH

// raw tdc sample width
`define TDC_WORD_W 32
// source tag in the low half-word of every record
`define TAG_W 16
// full record, word or marker pair above the tag
`define RECORD_W 48

// marker codes, sent twice above the tag
`define MARK_LINE_CODE 16'h000D
`define MARK_FRAME_CODE 16'h000E

// queue and uart defaults
`define DEFAULT_DEPTH_LOG2 4
`define DEFAULT_CLK_PER_BIT 4
`define UART_BYTES 6

`endif

//--- rtl/tdc_link_pkg.sv
`include "tdc_link_consts.svh"

package tdc_link_pkg;

    // one 48-bit record, two ways to read it
    // data view for tdc samples, marker view for line and frame markers
    typedef union packed {
        // tdc word above the tag
        struct packed {
            logic [`TDC_WORD_W-1:0] word;
            logic [`TAG_W-1:0]      tag;
        } data;
        // same marker code twice above the tag
        struct packed {
            logic [`TAG_W-1:0] code_hi;
            logic [`TAG_W-1:0] code_lo;
            logic [`TAG_W-1:0] tag;
        } mark;
    } link_record_u;

endpackage

//--- rtl/event_framer.sv
`timescale 1ns/1ps
`include "tdc_link_consts.svh"

module event_framer #(
    parameter logic [`TAG_W-1:0] source_tag = 'h0002
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`TDC_WORD_W-1:0]    tdc_word,
    input  logic                      tdc_valid,
    input  logic                      new_line,
    input  logic                      new_frame,
    input  logic                      full,
    output logic                      wr_en,
    output tdc_link_pkg::link_record_u record,
    output logic                      word_done,
    output logic                      line_done,
    output logic                      frame_done
);

    import tdc_link_pkg::*;

    // next record, built through whichever view fits the request
    link_record_u rec_nxt;
    // one-hot done, bit 0 word, bit 1 line, bit 2 frame
    logic [2:0]   done_nxt;
    logic         wr_nxt;

    // priority: data, then line, then frame
    always_comb begin
        rec_nxt  = '0;
        done_nxt = 3'b000;
        if (tdc_valid) begin
            rec_nxt.data.word = tdc_word;
            rec_nxt.data.tag  = source_tag;
            done_nxt          = 3'b001;
        end else if (new_line) begin
            rec_nxt.mark.code_hi = `MARK_LINE_CODE;
            rec_nxt.mark.code_lo = `MARK_LINE_CODE;
            rec_nxt.mark.tag     = source_tag;
            done_nxt             = 3'b010;
        end else if (new_frame) begin
            rec_nxt.mark.code_hi = `MARK_FRAME_CODE;
            rec_nxt.mark.code_lo = `MARK_FRAME_CODE;
            rec_nxt.mark.tag     = source_tag;
            done_nxt             = 3'b100;
        end
        // queue has no room, request is lost
        if (full) begin
            done_nxt = 3'b000;
        end
    end

    // any accepted request means a write
    assign wr_nxt = |done_nxt;

    // strobe and done pulses, one cycle each
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en      <= 1'b0;
            word_done  <= 1'b0;
            line_done  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            wr_en      <= wr_nxt;
            word_done  <= done_nxt[0];
            line_done  <= done_nxt[1];
            frame_done <= done_nxt[2];
        end
    end

    // record only loads on an accepted request
    always_ff @(posedge clk) begin
        if (wr_nxt) begin
            record <= rec_nxt;
        end
    end

endmodule

//--- rtl/record_queue.sv
`timescale 1ns/1ps
`include "tdc_link_consts.svh"

module record_queue #(
    parameter int depth_log2 = `DEFAULT_DEPTH_LOG2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  tdc_link_pkg::link_record_u record,
    output logic                       full,
    input  logic                       rd_en,
    output tdc_link_pkg::link_record_u head,
    output logic                       empty
);

    localparam int depth = 1 << depth_log2;

    // record storage
    logic [`RECORD_W-1:0] mem [depth];

    // one extra bit tells a wrapped writer from an equal one
    logic [depth_log2:0]  wr_ptr;
    logic [depth_log2:0]  rd_ptr;
    logic [depth_log2:0]  wr_ptr_nxt;
    logic [depth_log2:0]  rd_ptr_nxt;
    logic                 pop;

    // pop only what is really there
    assign pop = rd_en && !empty;

    assign wr_ptr_nxt = wr_en ? wr_ptr + 1'b1 : wr_ptr;
    assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_nxt;
            rd_ptr <= rd_ptr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[depth_log2-1:0]] <= record;
        end
    end

    // oldest entry always on head without a clock delay
    assign head  = mem[rd_ptr[depth_log2-1:0]];
    assign empty = (wr_ptr == rd_ptr);

    // full looks one edge ahead
    // the framer registers its strobe so the write in flight must count
    assign full = (wr_ptr_nxt[depth_log2] != rd_ptr_nxt[depth_log2]) &&
                  (wr_ptr_nxt[depth_log2-1:0] == rd_ptr_nxt[depth_log2-1:0]);

endmodule

//--- rtl/uart_record_tx.sv
`timescale 1ns/1ps
`include "tdc_link_consts.svh"

module uart_record_tx #(
    parameter int clk_per_bit = `DEFAULT_CLK_PER_BIT
) (
    input  logic                       clk,
    input  logic                       rst,
    input  tdc_link_pkg::link_record_u head,
    input  logic                       empty,
    output logic                       rd_en,
    output logic                       tx,
    output logic                       busy
);

    // counter wide enough even for one clock per bit
    localparam int cnt_w = (clk_per_bit > 1) ? $clog2(clk_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clk_per_bit - 1);
    localparam logic [2:0] last_byte = 3'(`UART_BYTES - 1);
    // frame is start, eight data, stop
    localparam logic [3:0] stop_idx = 4'd9;

    localparam logic st_idle = 1'b0;
    localparam logic st_send = 1'b1;

    logic                 state;
    logic [cnt_w-1:0]     cnt;
    // position inside the 10-bit frame
    logic [3:0]           bit_idx;
    // which of the six bytes is on the line
    logic [2:0]           byte_idx;
    // record being sent, current byte in the low 8 bits
    logic [`RECORD_W-1:0] shreg;
    logic                 bit_end;
    logic                 frame_end;

    // pop straight away when idle and something waits
    assign rd_en = (state == st_idle) && !empty;
    assign busy  = (state == st_send);

    assign bit_end   = (state == st_send) && (cnt == cnt_last);
    assign frame_end = bit_end && (bit_idx == stop_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            tx       <= 1'b1;
            cnt      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (rd_en) begin
            // start bit of byte 0 from the next edge
            state    <= st_send;
            tx       <= 1'b0;
            cnt      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (state == st_send) begin
            if (!bit_end) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
                if (frame_end) begin
                    bit_idx <= '0;
                    if (byte_idx == last_byte) begin
                        // line stays high after the last stop bit
                        state <= st_idle;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                        tx       <= 1'b0;
                    end
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    // data lsb first, then the stop bit
                    if (bit_idx == 4'd8) begin
                        tx <= 1'b1;
                    end else begin
                        tx <= shreg[bit_idx[2:0]];
                    end
                end
            end
        end
    end

    // load on pop, next byte down after each stop bit
    always_ff @(posedge clk) begin
        if (rd_en) begin
            shreg <= head;
        end else if (frame_end) begin
            shreg <= shreg >> 8;
        end
    end

endmodule

//--- rtl/tdc_stream_link.sv
`timescale 1ns/1ps
`include "tdc_link_consts.svh"

module tdc_stream_link #(
    parameter logic [`TAG_W-1:0] source_tag  = 'h0002,
    parameter int                depth_log2  = `DEFAULT_DEPTH_LOG2,
    parameter int                clk_per_bit = `DEFAULT_CLK_PER_BIT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`TDC_WORD_W-1:0] tdc_word,
    input  logic                   tdc_valid,
    input  logic                   new_line,
    input  logic                   new_frame,
    output logic                   word_done,
    output logic                   line_done,
    output logic                   frame_done,
    output logic                   tx,
    output logic                   tx_busy
);

    import tdc_link_pkg::*;

    // framer to queue
    logic         wr_en;
    logic         full;
    link_record_u record;
    // queue to uart
    logic         rd_en;
    logic         empty;
    link_record_u head;

    event_framer #(
        .source_tag (source_tag)
    ) u_framer (
        .clk        (clk),
        .rst        (rst),
        .tdc_word   (tdc_word),
        .tdc_valid  (tdc_valid),
        .new_line   (new_line),
        .new_frame  (new_frame),
        .full       (full),
        .wr_en      (wr_en),
        .record     (record),
        .word_done  (word_done),
        .line_done  (line_done),
        .frame_done (frame_done)
    );

    record_queue #(
        .depth_log2 (depth_log2)
    ) u_queue (
        .clk    (clk),
        .rst    (rst),
        .wr_en  (wr_en),
        .record (record),
        .full   (full),
        .rd_en  (rd_en),
        .head   (head),
        .empty  (empty)
    );

    // six bytes per record, lsb byte first
    uart_record_tx #(
        .clk_per_bit (clk_per_bit)
    ) u_uart (
        .clk   (clk),
        .rst   (rst),
        .head  (head),
        .empty (empty),
        .rd_en (rd_en),
        .tx    (tx),
        .busy  (tx_busy)
    );

endmodule

//--- tests/link_monitor.sv
`timescale 1ns/1ps
`include "tdc_link_consts.svh"

module link_monitor #(
    parameter logic [`TAG_W-1:0] source_tag  = 'h0002,
    parameter int                clk_per_bit = `DEFAULT_CLK_PER_BIT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`TDC_WORD_W-1:0] tdc_word,
    input  logic                   tdc_valid,
    input  logic                   new_line,
    input  logic                   new_frame,
    input  logic                   accept,
    input  logic                   word_done,
    input  logic                   line_done,
    input  logic                   frame_done,
    input  logic                   tx,
    input  logic                   tx_busy,
    output int                     rx_count,
    output int                     err_count
);

    import tdc_link_pkg::*;

    // negedges from start detection to mid start bit
    localparam int mid_wait = (clk_per_bit / 2 > 1) ? clk_per_bit / 2 - 1 : 0;

    // expected records in acceptance order, kind 0 word, 1 line, 2 frame
    link_record_u exp_q[$];
    logic [1:0]   kind_q[$];
    // done pulse owed by the request seen one negedge ago
    logic [2:0]   pend_done;
    logic [1:0]   kind;
    logic         seen_edge = 1'b0;
    int           done_errs = 0;
    int           rx_errs = 0;

    assign err_count = done_errs + rx_errs;

    function automatic bit value_ok(input string name, input logic [47:0] exp,
                                    input logic [47:0] got);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // word above tag, or marker code twice above tag
    function automatic link_record_u expected_record(input logic [1:0] k,
                                                     input logic [31:0] w);
        link_record_u r;
        logic [15:0]  code;
        r    = '0;
        code = (k == 2'd1) ? `MARK_LINE_CODE : `MARK_FRAME_CODE;
        if (k == 2'd0) begin
            r.data.word = w;
            r.data.tag  = source_tag;
        end else begin
            r.mark.code_hi = code;
            r.mark.code_lo = code;
            r.mark.tag     = source_tag;
        end
        return r;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            seen_edge <= 1'b1;
        end
    end

    // done pulses and reset state, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            pend_done = 3'b000;
            if (seen_edge) begin
                if (!value_ok("tx", 1'b1, tx)) done_errs++;
                if (!value_ok("tx_busy", 1'b0, tx_busy)) done_errs++;
                if (!value_ok("word_done", 1'b0, word_done)) done_errs++;
                if (!value_ok("line_done", 1'b0, line_done)) done_errs++;
                if (!value_ok("frame_done", 1'b0, frame_done)) done_errs++;
            end
        end else begin
            if (!value_ok("word_done", pend_done[0], word_done)) done_errs++;
            if (!value_ok("line_done", pend_done[1], line_done)) done_errs++;
            if (!value_ok("frame_done", pend_done[2], frame_done)) done_errs++;
            pend_done = 3'b000;
            // data beats line, line beats frame
            if (tdc_valid || new_line || new_frame) begin
                kind = tdc_valid ? 2'd0 : (new_line ? 2'd1 : 2'd2);
                if (accept) begin
                    pend_done[kind] = 1'b1;
                    exp_q.push_back(expected_record(kind, tdc_word));
                    kind_q.push_back(kind);
                end
            end
        end
    end

    task automatic wait_start();
        do @(negedge clk); while (rst || tx !== 1'b0);
    endtask

    // one uart frame, lsb first, sampled near mid-bit
    task automatic receive_byte(output logic [7:0] b);
        repeat (mid_wait) @(negedge clk);
        if (tx !== 1'b0) begin
            $display("start bit on tx ended early at t=%0t", $time);
            rx_errs++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (clk_per_bit) @(negedge clk);
            b[i] = tx;
        end
        repeat (clk_per_bit) @(negedge clk);
        if (tx !== 1'b1) begin
            $display("stop bit on tx missing at t=%0t", $time);
            rx_errs++;
        end
    endtask

    // decode through the view the expected kind calls for
    task automatic compare_record(input link_record_u got);
        link_record_u exp;
        logic [1:0]   k;
        if (exp_q.size() == 0) begin
            $display("record %0h arrived on tx at t=%0t with none expected", got, $time);
            rx_errs++;
        end else begin
            exp = exp_q.pop_front();
            k   = kind_q.pop_front();
            if (k == 2'd0) begin
                if (!value_ok("tx record word", exp.data.word, got.data.word)) rx_errs++;
                if (!value_ok("tx record tag", exp.data.tag, got.data.tag)) rx_errs++;
            end else begin
                if (!value_ok("tx record code_hi", exp.mark.code_hi, got.mark.code_hi))
                    rx_errs++;
                if (!value_ok("tx record code_lo", exp.mark.code_lo, got.mark.code_lo))
                    rx_errs++;
                if (!value_ok("tx record tag", exp.mark.tag, got.mark.tag)) rx_errs++;
            end
        end
        rx_count++;
    endtask

    // six bytes per record, least significant byte first
    initial begin : rx_decode
        logic [7:0]           rx_byte;
        logic [`RECORD_W-1:0] rx_bits;
        rx_count = 0;
        forever begin
            for (int n = 0; n < `UART_BYTES; n++) begin
                wait_start();
                receive_byte(rx_byte);
                rx_bits[n*8 +: 8] = rx_byte;
            end
            compare_record(rx_bits);
        end
    end

endmodule

//--- tests/tb_tdc_stream_link.sv
`timescale 1ns/1ps
`include "tdc_link_consts.svh"

module tb_tdc_stream_link;

    localparam int clk_per_bit = 4;
    localparam int max_cases = 32;

    logic                   clk;
    logic                   rst;
    logic [`TDC_WORD_W-1:0] tdc_word;
    logic                   tdc_valid;
    logic                   new_line;
    logic                   new_frame;
    logic                   accept;
    logic                   word_done;
    logic                   line_done;
    logic                   frame_done;
    logic                   tx;
    logic                   tx_busy;
    int                     rx_count;
    int                     err_count;

    // case table with requests packed as {tdc_valid, new_line, new_frame}
    int          case_id[max_cases];
    int          gap[max_cases];
    int          count[max_cases];
    int          exp_rec[max_cases];
    logic [2:0]  req[max_cases];
    logic [31:0] word[max_cases];
    int          n_cases;
    int          limit_cycles;
    int          cycle;
    int          target;
    int          passed;
    int          failed;

    tdc_stream_link #(
        .source_tag  (16'h0002),
        .depth_log2  (2),
        .clk_per_bit (clk_per_bit)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .tdc_word   (tdc_word),
        .tdc_valid  (tdc_valid),
        .new_line   (new_line),
        .new_frame  (new_frame),
        .word_done  (word_done),
        .line_done  (line_done),
        .frame_done (frame_done),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    link_monitor #(
        .source_tag  (16'h0002),
        .clk_per_bit (clk_per_bit)
    ) mon (
        .clk        (clk),
        .rst        (rst),
        .tdc_word   (tdc_word),
        .tdc_valid  (tdc_valid),
        .new_line   (new_line),
        .new_frame  (new_frame),
        .accept     (accept),
        .word_done  (word_done),
        .line_done  (line_done),
        .frame_done (frame_done),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .rx_count   (rx_count),
        .err_count  (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit armed once the case table is known
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit_cycles > 0 && cycle >= limit_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    // lines starting with # are comments
    task automatic read_cases();
        int          fd;
        int          got;
        string       text;
        int          c;
        int          g;
        int          n;
        int          e;
        logic        v;
        logic        l;
        logic        f;
        logic [31:0] w;
        n_cases = 0;
        fd = $fopen("tests/link_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = "";
                got  = $fgets(text, fd);
                if (got > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    got = $sscanf(text, "%d %d %d %b %b %b %h %d", c, g, n, v, l, f, w, e);
                    if (got == 8 && n_cases < max_cases) begin
                        case_id[n_cases] = c;
                        gap[n_cases]     = g;
                        count[n_cases]   = n;
                        req[n_cases]     = {v, l, f};
                        word[n_cases]    = w;
                        exp_rec[n_cases] = e;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one burst and the wait for its records to leave on tx
    task automatic run_case(input int k);
        int errs_before;
        bit ok;
        errs_before = err_count;
        ok          = 1'b1;
        repeat (gap[k]) @(posedge clk);
        for (int i = 0; i < count[k]; i++) begin
            @(posedge clk);
            tdc_valid <= req[k][2];
            new_line  <= req[k][1];
            new_frame <= req[k][0];
            tdc_word  <= word[k] + i;
            // queue room for the first exp_rec requests only
            accept    <= (i < exp_rec[k]);
        end
        @(posedge clk);
        tdc_valid <= 1'b0;
        new_line  <= 1'b0;
        new_frame <= 1'b0;
        accept    <= 1'b0;
        target += exp_rec[k];
        while (rx_count < target || tx_busy) @(negedge clk);
        repeat (4) @(negedge clk);
        if (tx_busy !== 1'b0 || rx_count != target) begin
            $display("case %0d: more records left the link than were accepted", case_id[k]);
            ok = 1'b0;
        end
        if (err_count != errs_before) ok = 1'b0;
        if (ok) begin
            passed++;
            $display("case %0d: pass, %0d records", case_id[k], exp_rec[k]);
        end else begin
            failed++;
            $display("case %0d: FAIL", case_id[k]);
        end
    endtask

    initial begin
        rst          = 1'b1;
        tdc_word     = '0;
        tdc_valid    = 1'b0;
        new_line     = 1'b0;
        new_frame    = 1'b0;
        accept       = 1'b0;
        cycle        = 0;
        limit_cycles = 0;
        target       = 0;
        passed       = 0;
        failed       = 0;
        read_cases();
        // gaps plus a full record time each plus slack
        limit_cycles = 200;
        for (int k = 0; k < n_cases; k++) begin
            limit_cycles += gap[k] + exp_rec[k] * 60 * clk_per_bit;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (err_count == 0) begin
            passed++;
            $display("reset state: pass");
        end else begin
            failed++;
            $display("reset state: FAIL");
        end
        if (n_cases == 0) begin
            $display("no cases could be read from tests/link_cases.txt");
            failed++;
        end
        for (int k = 0; k < n_cases; k++) begin
            run_case(k);
        end
        $display("tests: %0d passed, %0d failed, %0d checker errors", passed, failed, err_count);
        if (failed == 0 && err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tdc_stream_link.f
+incdir+rtl
rtl/tdc_link_pkg.sv
rtl/event_framer.sv
rtl/record_queue.sv
rtl/uart_record_tx.sv
rtl/tdc_stream_link.sv
tests/link_monitor.sv
tests/tb_tdc_stream_link.sv

//--- Bender.yml
package:
  name: tdc_stream_link

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tdc_link_pkg.sv
      - rtl/event_framer.sv
      - rtl/record_queue.sv
      - rtl/uart_record_tx.sv
      - rtl/tdc_stream_link.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/link_monitor.sv
      - tests/tb_tdc_stream_link.sv

//--- tests/link_cases.txt
# case gap count tdc_valid new_line new_frame tdc_word(hex) expected_records
# gap in cycles before the case, count of back-to-back request cycles
1 5 1 1 0 0 A5C30F17 1
2 5 1 0 1 0 00000000 1
3 5 1 0 0 1 00000000 1
4 5 1 1 1 0 12345678 1
5 5 1 0 1 1 00000000 1
6 10 1 1 0 0 DEADBEEF 1
7 3 1 1 0 0 0000FFFF 1
8 3 1 1 0 0 80000001 1
9 5 8 1 0 0 C0DE0000 5
